// ==== mult_pkg.sv ====
`default_nettype none

package mult_pkg;

  // Datapath word width.
  parameter int DATA_W = 32;

  // Operand slice handled by one multiplier stage.
  parameter int LIMB_W = 16;

  // Modulus, mu and quotient estimate.
  typedef logic [DATA_W-1:0]   word_t;

  // Input x and unreduced remainders.
  typedef logic [2*DATA_W-1:0] dword_t;

  // Product of x and mu.
  typedef logic [3*DATA_W-1:0] tword_t;

endpackage : mult_pkg

`default_nettype wire

// ==== barrett_pkg.sv ====
`default_nettype none

package barrett_pkg;

  import mult_pkg::*;

  // Bit length k of the modulus.
  typedef logic [5:0] bitlen_t;

  // Parameter set of one modulus, fixed while the modulus is in use.
  typedef struct packed {
    word_t   q;   // Modulus.
    bitlen_t k;   // Bit length of q.
    word_t   mu;  // Floor of 2^(2k) / q.
  } barrett_param_t;

  // Modulus setup FSM.
  typedef enum logic [1:0] {
    SETUP_IDLE   = 2'd0,
    SETUP_DIVIDE = 2'd1,
    SETUP_DONE   = 2'd2
  } setup_state_e;

endpackage : barrett_pkg

`default_nettype wire

// ==== mul_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_pipe import mult_pkg::*; #(
  parameter int A_W        = 2 * DATA_W,
  parameter int NUM_STAGES = DATA_W / LIMB_W
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  in_valid_i,
  input  logic [A_W-1:0]        a_i,
  input  word_t                 b_i,
  output logic                  out_valid_o,
  output logic [A_W+DATA_W-1:0] p_o
);

  localparam int MUL_LAT = NUM_STAGES + 2;
  localparam int B_W     = NUM_STAGES * LIMB_W;
  localparam int P_W     = A_W + DATA_W;

  logic [NUM_STAGES:0] v_q;                 // Valid bit per pipeline register.
  logic [A_W-1:0]      a_q   [NUM_STAGES];  // Operand A travelling with its item.
  logic [B_W-1:0]      b_q   [NUM_STAGES];  // Operand B travelling with its item.
  logic [P_W-1:0]      acc_q [NUM_STAGES];  // Running partial sum.
  logic [P_W-1:0]      part  [NUM_STAGES];

  // One limb of B times the whole of A, moved to the limb's weight.
  for (genvar s = 0; s < NUM_STAGES; s++) begin : g_limb
    logic [A_W+LIMB_W-1:0] prod;

    assign prod    = a_q[s] * b_q[s][s*LIMB_W +: LIMB_W];
    assign part[s] = P_W'(prod) << (s * LIMB_W);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      v_q         <= '0;
      out_valid_o <= 1'b0;
    end else begin
      v_q         <= {v_q[NUM_STAGES-1:0], in_valid_i};
      out_valid_o <= v_q[NUM_STAGES];
    end
  end

  always_ff @(posedge clk_i) begin
    a_q[0]   <= a_i;                 // Input register.
    b_q[0]   <= B_W'(b_i);
    acc_q[0] <= part[0];             // First limb starts the sum.
    for (int s = 1; s < NUM_STAGES; s++) begin
      a_q[s]   <= a_q[s-1];
      b_q[s]   <= b_q[s-1];
      acc_q[s] <= acc_q[s-1] + part[s];
    end
    p_o <= acc_q[NUM_STAGES-1];      // Output register.
  end

  // Nothing can come out before a full trip through the pipeline.
  assert property (@(posedge clk_i) $rose(rst_ni) |-> !out_valid_o [*MUL_LAT])
    else $error("mul_pipe: out_valid_o high too early after reset");

endmodule : mul_pipe

`default_nettype wire

// ==== delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             valid_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o
);

  logic [DEPTH-1:0] vld_q;
  logic [WIDTH-1:0] data_q [DEPTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= valid_i;
      for (int i = 1; i < DEPTH; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    data_q[0] <= data_i;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign valid_o = vld_q[DEPTH-1];
  assign data_o  = data_q[DEPTH-1];

endmodule : delay_line

`default_nettype wire

// ==== barrett_param_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrett_param_calc import mult_pkg::*, barrett_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           cfg_valid_i,
  input  word_t          cfg_q_i,
  output logic           cfg_ready_o,
  output barrett_param_t params_o
);

  setup_state_e               state_q;
  logic [$bits(bitlen_t):0]   cnt_q;    // Index of the dividend bit being processed.
  word_t                      q_q;
  bitlen_t                    k_q;
  word_t                      rem_q;    // Partial remainder.
  word_t                      mu_q;     // Quotient bits so far.
  logic                       ovf_q;    // Quotient ran past the word.
  word_t                      rem_shl;
  word_t                      mu_final;
  logic                       accept;
  logic                       div_bit;

  // Position of the highest set bit, plus one.
  function automatic bitlen_t bit_length(word_t v);
    bitlen_t len;
    len = '0;
    for (int i = 0; i < DATA_W; i++) begin
      if (v[i]) len = bitlen_t'(i + 1);
    end
    return len;
  endfunction

  assign cfg_ready_o = (state_q == SETUP_IDLE);
  assign accept      = cfg_valid_i && cfg_ready_o;

  // Dividend is 2^(2k), so only its top bit is set.
  assign div_bit  = (cnt_q == {k_q, 1'b0});
  assign rem_shl  = {rem_q[DATA_W-2:0], div_bit};
  assign mu_final = ovf_q ? '1 : mu_q;  // Saturates for a power-of-two q of full width.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= SETUP_IDLE;
      cnt_q    <= '0;
      params_o <= '0;
    end else begin
      unique case (state_q)
        SETUP_IDLE: begin
          if (accept) begin
            state_q <= SETUP_DIVIDE;
            cnt_q   <= {bit_length(cfg_q_i), 1'b0};
          end
        end
        SETUP_DIVIDE: begin
          if (cnt_q == '0) begin
            state_q <= SETUP_DONE;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        SETUP_DONE: begin
          params_o <= '{q: q_q, k: k_q, mu: mu_final};
          state_q  <= SETUP_IDLE;
        end
        default: state_q <= SETUP_IDLE;
      endcase
    end
  end

  // Restoring division, one quotient bit per clock.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      q_q   <= cfg_q_i;
      k_q   <= bit_length(cfg_q_i);
      rem_q <= '0;
      mu_q  <= '0;
      ovf_q <= 1'b0;
    end else if (state_q == SETUP_DIVIDE) begin
      ovf_q <= ovf_q | mu_q[DATA_W-1];
      if (rem_shl >= q_q) begin
        rem_q <= rem_shl - q_q;
        mu_q  <= {mu_q[DATA_W-2:0], 1'b1};
      end else begin
        rem_q <= rem_shl;
        mu_q  <= {mu_q[DATA_W-2:0], 1'b0};
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) accept |-> cfg_q_i != '0)
    else $error("barrett_param_calc: zero modulus accepted");

endmodule : barrett_param_calc

`default_nettype wire

// ==== barrett_reduce.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrett_reduce import mult_pkg::*, barrett_pkg::*; #(
  parameter int NUM_STAGES = DATA_W / LIMB_W
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           start_i,
  input  dword_t         x_i,
  input  barrett_param_t params_i,
  input  logic           busy_i,
  output logic           valid_o,
  output word_t          result_o
);

  localparam int MUL_LAT = NUM_STAGES + 2;

  tword_t xmu;             // x * mu.
  logic   xmu_v;
  word_t  est_q;           // Quotient estimate.
  logic   est_v_q;
  dword_t qm;              // Estimate * q.
  logic   qm_v;
  dword_t x_dly;
  logic   x_dly_v;
  dword_t rem0_q, rem1_q;  // Remainder before and after the first correction.
  logic   rem0_v_q, rem1_v_q;
  dword_t q_ext;

  assign q_ext = dword_t'(params_i.q);

  // The multiplier's own input register takes x.
  mul_pipe #(
    .A_W        (2 * DATA_W),
    .NUM_STAGES (NUM_STAGES)
  ) u_mul_xmu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (start_i),
    .a_i         (x_i),
    .b_i         (params_i.mu),
    .out_valid_o (xmu_v),
    .p_o         (xmu)
  );

  // Shift by 2k.
  always_ff @(posedge clk_i) begin
    est_q <= word_t'(xmu >> {params_i.k, 1'b0});
  end

  mul_pipe #(
    .A_W        (DATA_W),
    .NUM_STAGES (NUM_STAGES)
  ) u_mul_qm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (est_v_q),
    .a_i         (est_q),
    .b_i         (params_i.q),
    .out_valid_o (qm_v),
    .p_o         (qm)
  );

  // x lines up with the second product.
  delay_line #(
    .WIDTH ($bits(dword_t)),
    .DEPTH (2 * MUL_LAT + 1)
  ) u_x_dly (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (start_i),
    .data_i  (x_i),
    .valid_o (x_dly_v),
    .data_o  (x_dly)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      est_v_q  <= 1'b0;
      rem0_v_q <= 1'b0;
      rem1_v_q <= 1'b0;
      valid_o  <= 1'b0;
    end else begin
      est_v_q  <= xmu_v;
      rem0_v_q <= qm_v;
      rem1_v_q <= rem0_v_q;
      valid_o  <= rem1_v_q;
    end
  end

  // Estimate is short by at most two, so two corrections suffice.
  always_ff @(posedge clk_i) begin
    rem0_q   <= x_dly - qm;
    rem1_q   <= (rem0_q >= q_ext) ? rem0_q - q_ext : rem0_q;
    result_o <= word_t'((rem1_q >= q_ext) ? rem1_q - q_ext : rem1_q);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(start_i && busy_i))
    else $error("barrett_reduce: start_i during modulus setup");

  // Delayed x and the second product belong to the same item.
  assert property (@(posedge clk_i) disable iff (!rst_ni) x_dly_v == qm_v)
    else $error("barrett_reduce: x delay out of step with multipliers");

endmodule : barrett_reduce

`default_nettype wire

// ==== modred_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module modred_top import mult_pkg::*, barrett_pkg::*; #(
  parameter int NUM_STAGES = DATA_W / LIMB_W
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   cfg_valid_i,
  input  word_t  cfg_q_i,
  output logic   cfg_ready_o,
  input  logic   start_i,
  input  dword_t x_i,
  output logic   valid_o,
  output word_t  result_o
);

  barrett_param_t params;  // Held by the setup unit while ready.

  barrett_param_calc u_param_calc (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_valid_i (cfg_valid_i),
    .cfg_q_i     (cfg_q_i),
    .cfg_ready_o (cfg_ready_o),
    .params_o    (params)
  );

  barrett_reduce #(
    .NUM_STAGES (NUM_STAGES)
  ) u_reduce (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .x_i      (x_i),
    .params_i (params),
    .busy_i   (!cfg_ready_o),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

endmodule : modred_top

`default_nettype wire

// ==== tb_modred.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_modred import mult_pkg::*;;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYC  = 4;
  localparam int NUM_STAGES = 2;
  localparam int LATENCY    = 2 * (NUM_STAGES + 2) + 4;  // Start to valid_o.
  localparam int NUM_EDGE   = 5;
  localparam int NUM_STREAM = 200;
  localparam int NUM_GAPPED = 60;                        // Per modulus.
  localparam int MAX_GAP    = 3;
  localparam int NUM_MODULI = 3;
  localparam int SETUP_CYC  = 70;
  localparam int WATCHDOG_CYC = RESET_CYC + 20 + NUM_EDGE * (2 * LATENCY + 1)
                              + NUM_STREAM * 2 + 2 * NUM_GAPPED * (MAX_GAP + 1)
                              + NUM_MODULI * SETUP_CYC + 4 * LATENCY + 200;

  typedef struct packed {
    logic [31:0] issue;  // Cycle count when start_i was driven.
    word_t       value;
  } expect_t;

  logic   clk_i;
  logic   rst_ni;
  logic   cfg_valid_i;
  word_t  cfg_q_i;
  logic   cfg_ready_o;
  logic   start_i;
  dword_t x_i;
  logic   valid_o;
  word_t  result_o;

  integer      seed = 32'h774e;
  logic [31:0] cyc  = '0;
  word_t       cur_q;
  expect_t     exp_q [$];

  modred_top #(
    .NUM_STAGES (NUM_STAGES)
  ) dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_valid_i (cfg_valid_i),
    .cfg_q_i     (cfg_q_i),
    .cfg_ready_o (cfg_ready_o),
    .start_i     (start_i),
    .x_i         (x_i),
    .valid_o     (valid_o),
    .result_o    (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped.");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      abort_run($sformatf("[ERROR] %0t: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("[ERROR] %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  function automatic word_t mod_ref(input dword_t x, input word_t q);
    return word_t'(x % dword_t'(q));
  endfunction

  function automatic int bit_len(input word_t v);
    int len;
    len = 0;
    while (v != '0) begin
      len++;
      v = v >> 1;
    end
    return len;
  endfunction

  function automatic dword_t rand_below_sq(input word_t q);
    dword_t r;
    r = {$random(seed), $random(seed)};
    return r % (dword_t'(q) * dword_t'(q));
  endfunction

  // Every falling edge checks valid_o against the oldest pending item.
  task automatic next_cycle();
    expect_t head;
    @(negedge clk_i);
    if (exp_q.size() > 0 && (cyc - exp_q[0].issue) == LATENCY) begin
      head = exp_q.pop_front();
      check_bit("valid_o", 1'b1, valid_o);
      check_word("result_o", head.value, result_o);
    end else begin
      check_bit("valid_o", 1'b0, valid_o);
    end
  endtask

  task automatic send(input dword_t x);
    expect_t item;
    item.issue  = cyc;
    item.value  = mod_ref(x, cur_q);
    start_i     = 1'b1;
    x_i         = x;
    exp_q.push_back(item);
    next_cycle();
    start_i = 1'b0;
  endtask

  task automatic drain();
    for (int i = 0; i < 2 * LATENCY && exp_q.size() > 0; i++) begin
      next_cycle();
    end
    if (exp_q.size() != 0) abort_run("Results missing after the pipeline should be empty.");
  endtask

  task automatic load_modulus(input word_t q);
    int k;
    int waited;
    k           = bit_len(q);
    cfg_valid_i = 1'b1;
    cfg_q_i     = q;
    next_cycle();
    cfg_valid_i = 1'b0;
    check_bit("cfg_ready_o", 1'b0, cfg_ready_o);
    waited = 1;
    while (!cfg_ready_o && waited < 2 * k + 3) begin  // Ends on the rise of ready.
      next_cycle();
      waited++;
    end
    if (!cfg_ready_o) abort_run("cfg_ready_o did not return after the modulus setup.");
    cur_q = q;
  endtask

  task automatic test_reset_state();
    repeat (20) begin
      next_cycle();
      check_bit("cfg_ready_o", 1'b1, cfg_ready_o);
    end
  endtask

  task automatic test_setup_handshake();
    load_modulus(32'd1000003);
  endtask

  task automatic test_edge_values();
    dword_t q;
    q = dword_t'(cur_q);
    send(64'd0);
    drain();
    send(q - 1);
    drain();
    send(q);
    drain();
    send(2 * q + 5);
    drain();
    send(q * q - 1);  // Largest legal input.
    drain();
  endtask

  task automatic test_full_rate_stream();
    repeat (NUM_STREAM) send(rand_below_sq(cur_q));
    drain();
  endtask

  task automatic send_gapped(input int count);
    int gap;
    repeat (count) begin
      send(rand_below_sq(cur_q));
      gap = $unsigned($random(seed)) % (MAX_GAP + 1);
      repeat (gap) next_cycle();
    end
    drain();
  endtask

  task automatic test_gapped_new_modulus();
    load_modulus(32'd3);
    send_gapped(NUM_GAPPED);
    load_modulus(32'h7fff_ffff);
    send_gapped(NUM_GAPPED);
  endtask

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    abort_run("Watchdog expired before the tests finished.");
  end

  initial begin
    rst_ni      = 1'b0;
    cfg_valid_i = 1'b0;
    cfg_q_i     = '0;
    start_i     = 1'b0;
    x_i         = '0;
    cur_q       = '0;
    repeat (RESET_CYC) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_state();
    test_setup_handshake();
    test_edge_values();
    test_full_rate_stream();
    test_gapped_new_modulus();
    $display("Test passed");
    $finish;
  end

endmodule : tb_modred

`default_nettype wire

// ==== all.f ====
mult_pkg.sv
barrett_pkg.sv
mul_pipe.sv
delay_line.sv
barrett_param_calc.sv
barrett_reduce.sv
modred_top.sv
tb_modred.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the modular reducer testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_modred \
  -o tb_modred \
  && ./obj_dir/tb_modred 2>&1 | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }
grep -q "Test passed" sim.log && exit 0 || exit 1
